/* project.f */
cu_pkg.sv
alu_op_decoder.sv
mem_stack_decoder.sv
program_flow_decoder.sv
ctrl_word_register.sv
control_unit.sv
tb_clock_gen.sv
tb_control_unit.sv

/* Makefile */
TOP = tb_control_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module control_unit cu_pkg.sv alu_op_decoder.sv \
		mem_stack_decoder.sv program_flow_decoder.sv ctrl_word_register.sv control_unit.sv
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --top-module $(TOP) -f project.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* tb_control_unit.sv */
module tb_control_unit
  import cu_pkg::*;
();

  localparam int unsigned num_vectors = 3000;
  localparam int unsigned timeout     = num_vectors * 8 + 400;

  logic       cu_clk;
  logic       arst_n;
  logic       decode_stb;
  decode_in_t dec_in;
  ctrl_word_t ctrl;
  logic       ctrl_valid;
  logic       illegal;

  logic [31:0] lfsr_state;
  string       ctx;  // Current vector, for error lines

  tb_clock_gen tb_clock_gen_inst (
    .cu_clk (cu_clk),
    .arst_n (arst_n)
  );

  control_unit control_unit_inst (
    .cu_clk     (cu_clk),
    .arst_n     (arst_n),
    .decode_stb (decode_stb),
    .dec_in     (dec_in),
    .ctrl       (ctrl),
    .ctrl_valid (ctrl_valid),
    .illegal    (illegal)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random bits
  ////////////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] val);
    int unsigned k;
    val = '0;
    for (k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic ctrl_word_t model_word(input logic [6:0] op, input logic c,
                                            input logic z, output logic ill);
    ctrl_word_t w;
    alu_sel_e   sel;
    logic       alu_op;
    w      = '0;
    ill    = 1'b0;
    alu_op = 1'b1;
    sel    = alu_add;
    casez (op)  // RR form first, RI class after it
      7'b0000000, 7'b10000??: sel = alu_and;
      7'b0000001, 7'b10001??: sel = alu_or;
      7'b0000010, 7'b10010??: sel = alu_exor;
      7'b0000011, 7'b10011??: sel = alu_test;
      7'b0000100, 7'b10100??: sel = alu_add;
      7'b0000101, 7'b10101??: sel = alu_addc;
      7'b0000110, 7'b10110??: sel = alu_sub;
      7'b0000111, 7'b10111??: sel = alu_subc;
      7'b0001000, 7'b11000??: sel = alu_cmp;
      7'b0001001, 7'b11011??: sel = alu_mov;
      7'b0100000: sel = alu_lsl;
      7'b0100001: sel = alu_lsr;
      7'b0100010: sel = alu_rol;
      7'b0100011: sel = alu_ror;
      7'b0100100: sel = alu_asr;
      default:    alu_op = 1'b0;
    endcase
    if (alu_op) begin
      w.alu_sel     = sel;
      w.alu_opy_sel = op[6];  // All ALU immediates sit in the upper half
      w.rf_wr       = !(sel inside {alu_cmp, alu_test});
      if (sel inside {alu_and, alu_or, alu_exor, alu_test}) begin
        w.flg_c_clr = 1'b1;
        w.flg_z_ld  = 1'b1;
      end else if (sel != alu_mov) begin
        w.flg_c_ld = 1'b1;
        w.flg_z_ld = 1'b1;
      end
      return w;
    end
    casez (op)
      7'b0001010: begin  // LD reg
        w.rf_wr     = 1'b1;
        w.rf_wr_sel = rf_scratch;
      end
      7'b11100??: begin
        w.rf_wr        = 1'b1;
        w.rf_wr_sel    = rf_scratch;
        w.scr_addr_sel = scr_imm;
      end
      7'b0001011: w.scr_we = 1'b1;                                          // ST reg
      7'b11101??: begin
        w.scr_we       = 1'b1;
        w.scr_addr_sel = scr_imm;
      end
      7'b0100101: begin                                                     // PUSH
        w.sp_decr      = 1'b1;
        w.scr_we       = 1'b1;
        w.scr_addr_sel = scr_sp_dec;
      end
      7'b0100110: begin                                                     // POP
        w.sp_incr      = 1'b1;
        w.scr_addr_sel = scr_sp;
        w.rf_wr        = 1'b1;
        w.rf_wr_sel    = rf_scratch;
      end
      7'b0101000: w.sp_ld = 1'b1;
      7'b11001??: begin  // IN
        w.rf_wr     = 1'b1;
        w.rf_wr_sel = rf_io;
      end
      7'b11010??: w.io_strb = 1'b1;
      7'b0010000: w.pc_ld = 1'b1;                                           // BRN
      7'b0010001: begin                                                     // CALL
        w.pc_ld        = 1'b1;
        w.sp_decr      = 1'b1;
        w.scr_we       = 1'b1;
        w.scr_data_sel = 1'b1;
        w.scr_addr_sel = scr_sp_dec;
      end
      7'b0010010: w.pc_ld = z;   // BREQ
      7'b0010011: w.pc_ld = !z;  // BRNE
      7'b0010100: w.pc_ld = c;   // BRCS
      7'b0010101: w.pc_ld = !c;  // BRCC
      7'b0110010, 7'b0110110, 7'b0110111: begin
        w.pc_ld        = 1'b1;
        w.pc_sel       = pc_stack;
        w.sp_incr      = 1'b1;
        w.scr_addr_sel = scr_sp;
      end
      7'b0110000: w.flg_c_clr = 1'b1;
      7'b0110001: w.flg_c_set = 1'b1;
      7'b0110100: w.i_set = 1'b1;
      7'b0110101: w.i_clr = 1'b1;
      default:    ill = 1'b1;
    endcase
    // RETID and RETIE bring back the shadow flags
    if (op == 7'b0110110 || op == 7'b0110111) begin
      w.flg_ld_sel = 1'b1;
      w.flg_c_ld   = 1'b1;
      w.flg_z_ld   = 1'b1;
      w.i_clr      = (op == 7'b0110110);
      w.i_set      = (op == 7'b0110111);
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %0h, expected %0h (%s)", $time, what, got, exp, ctx);
      $display("Simulation finished: FAIL");
      $fatal(1, "Output mismatch on %s", what);
    end
  endtask

  task automatic expect_outputs(input ctrl_word_t exp_w, input logic exp_ill,
                                input logic exp_valid);
    check_value("ctrl_valid", 32'(ctrl_valid), 32'(exp_valid));
    check_value("illegal", 32'(illegal), 32'(exp_ill));
    check_value("pc_ld", 32'(ctrl.pc_ld), 32'(exp_w.pc_ld));
    check_value("pc_sel", 32'(ctrl.pc_sel), 32'(exp_w.pc_sel));
    check_value("sp_ld", 32'(ctrl.sp_ld), 32'(exp_w.sp_ld));
    check_value("sp_incr", 32'(ctrl.sp_incr), 32'(exp_w.sp_incr));
    check_value("sp_decr", 32'(ctrl.sp_decr), 32'(exp_w.sp_decr));
    check_value("rf_wr", 32'(ctrl.rf_wr), 32'(exp_w.rf_wr));
    check_value("rf_wr_sel", 32'(ctrl.rf_wr_sel), 32'(exp_w.rf_wr_sel));
    check_value("alu_opy_sel", 32'(ctrl.alu_opy_sel), 32'(exp_w.alu_opy_sel));
    check_value("alu_sel", 32'(ctrl.alu_sel), 32'(exp_w.alu_sel));
    check_value("scr_we", 32'(ctrl.scr_we), 32'(exp_w.scr_we));
    check_value("scr_data_sel", 32'(ctrl.scr_data_sel), 32'(exp_w.scr_data_sel));
    check_value("scr_addr_sel", 32'(ctrl.scr_addr_sel), 32'(exp_w.scr_addr_sel));
    check_value("flg_c_set", 32'(ctrl.flg_c_set), 32'(exp_w.flg_c_set));
    check_value("flg_c_clr", 32'(ctrl.flg_c_clr), 32'(exp_w.flg_c_clr));
    check_value("flg_c_ld", 32'(ctrl.flg_c_ld), 32'(exp_w.flg_c_ld));
    check_value("flg_z_ld", 32'(ctrl.flg_z_ld), 32'(exp_w.flg_z_ld));
    check_value("flg_ld_sel", 32'(ctrl.flg_ld_sel), 32'(exp_w.flg_ld_sel));
    check_value("flg_shad_ld", 32'(ctrl.flg_shad_ld), 32'(exp_w.flg_shad_ld));
    check_value("i_set", 32'(ctrl.i_set), 32'(exp_w.i_set));
    check_value("i_clr", 32'(ctrl.i_clr), 32'(exp_w.i_clr));
    check_value("io_strb", 32'(ctrl.io_strb), 32'(exp_w.io_strb));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    ctrl_word_t  exp_w;
    logic        exp_ill;
    logic        ill;
    logic        stb;
    logic [31:0] bits;
    logic [6:0]  op;
    int unsigned i;
    decode_stb = 1'b0;
    dec_in     = '0;
    lfsr_state = 32'ha6f117f4;
    exp_w      = '0;
    exp_ill    = 1'b0;
    ctx        = "during reset";
    @(posedge cu_clk);
    @(negedge cu_clk);
    expect_outputs(exp_w, exp_ill, 1'b0);
    wait (arst_n === 1'b1);
    ctx = "after reset";
    @(negedge cu_clk);
    expect_outputs(exp_w, exp_ill, 1'b0);
    for (i = 0; i < num_vectors; i++) begin
      take_bits(2, bits);
      stb = (bits[1:0] != 2'b00);  // Mostly strobes, so runs come back to back
      take_bits(7, bits);
      op = bits[6:0];
      take_bits(2, bits);
      decode_stb       = stb;
      dec_in.opcode.rr = op;
      dec_in.c         = bits[1];
      dec_in.z         = bits[0];
      if (stb) begin
        exp_w = model_word(op, bits[1], bits[0], ill);
        exp_ill = ill;
      end
      ctx = $sformatf("vector %0d op %02h c %0b z %0b stb %0b", i, op, bits[1], bits[0], stb);
      @(negedge cu_clk);
      expect_outputs(exp_w, exp_ill, stb);  // Word holds when no strobe
    end
    decode_stb = 1'b0;
    ctx = "idle after last vector";
    @(negedge cu_clk);
    expect_outputs(exp_w, exp_ill, 1'b0);
    $display("Simulation finished: PASS");
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout);
    $display("Timeout: the test did not finish within %0d time units", timeout);
    $display("Simulation finished: FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
  output logic cu_clk,
  output logic arst_n
);

  // Period 8
  initial begin
    cu_clk = 1'b0;
    forever #4 cu_clk = ~cu_clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge cu_clk);
    @(negedge cu_clk);  // Release away from the active edge
    arst_n = 1'b1;
  end

endmodule

/* control_unit.sv */
module control_unit
  import cu_pkg::*;
(
  input  logic       cu_clk,
  input  logic       arst_n,
  input  logic       decode_stb,
  input  decode_in_t dec_in,
  output ctrl_word_t ctrl,
  output logic       ctrl_valid,
  output logic       illegal
);

  ////////////////////////////////////////////////////////////////////////////
  // Combinational class decoders
  ////////////////////////////////////////////////////////////////////////////

  ctrl_word_t alu_word;
  ctrl_word_t mem_word;
  ctrl_word_t flow_word;
  logic       alu_hit;
  logic       mem_hit;
  logic       flow_hit;

  alu_op_decoder alu_op_decoder_inst (
    .dec_in (dec_in),
    .word   (alu_word),
    .hit    (alu_hit)
  );

  mem_stack_decoder mem_stack_decoder_inst (
    .dec_in (dec_in),
    .word   (mem_word),
    .hit    (mem_hit)
  );

  program_flow_decoder program_flow_decoder_inst (
    .dec_in (dec_in),
    .word   (flow_word),
    .hit    (flow_hit)
  );

  // Merge and register, result one cycle after the strobe
  ctrl_word_register ctrl_word_register_inst (
    .cu_clk     (cu_clk),
    .arst_n     (arst_n),
    .decode_stb (decode_stb),
    .alu_word   (alu_word),
    .mem_word   (mem_word),
    .flow_word  (flow_word),
    .alu_hit    (alu_hit),
    .mem_hit    (mem_hit),
    .flow_hit   (flow_hit),
    .ctrl       (ctrl),
    .ctrl_valid (ctrl_valid),
    .illegal    (illegal)
  );

endmodule

/* ctrl_word_register.sv */
module ctrl_word_register
  import cu_pkg::*;
(
  input  logic       cu_clk,
  input  logic       arst_n,
  input  logic       decode_stb,
  input  ctrl_word_t alu_word,
  input  ctrl_word_t mem_word,
  input  ctrl_word_t flow_word,
  input  logic       alu_hit,
  input  logic       mem_hit,
  input  logic       flow_hit,
  output ctrl_word_t ctrl,
  output logic       ctrl_valid,
  output logic       illegal
);

  ctrl_word_t merged;
  logic       any_hit;

  // Partial words are zero outside their class, so OR is the merge
  assign merged  = ctrl_word_t'(alu_word | mem_word | flow_word);
  assign any_hit = alu_hit | mem_hit | flow_hit;

  always_ff @(posedge cu_clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl       <= '0;
      ctrl_valid <= 1'b0;
      illegal    <= 1'b0;
    end else begin
      ctrl_valid <= decode_stb;  // One pulse per strobe
      if (decode_stb) begin
        ctrl    <= merged;
        illegal <= !any_hit;     // Word is already all zero here
      end
    end
  end

endmodule

/* program_flow_decoder.sv */
module program_flow_decoder
  import cu_pkg::*;
(
  input  decode_in_t dec_in,
  output ctrl_word_t word,
  output logic       hit
);

  localparam logic [opcode_w-1:0] op_brn   = 7'b0010000;
  localparam logic [opcode_w-1:0] op_call  = 7'b0010001;
  localparam logic [opcode_w-1:0] op_breq  = 7'b0010010;
  localparam logic [opcode_w-1:0] op_brne  = 7'b0010011;
  localparam logic [opcode_w-1:0] op_brcs  = 7'b0010100;
  localparam logic [opcode_w-1:0] op_brcc  = 7'b0010101;
  localparam logic [opcode_w-1:0] op_clc   = 7'b0110000;
  localparam logic [opcode_w-1:0] op_sec   = 7'b0110001;
  localparam logic [opcode_w-1:0] op_ret   = 7'b0110010;
  localparam logic [opcode_w-1:0] op_sei   = 7'b0110100;
  localparam logic [opcode_w-1:0] op_cli   = 7'b0110101;
  localparam logic [opcode_w-1:0] op_retid = 7'b0110110;
  localparam logic [opcode_w-1:0] op_retie = 7'b0110111;

  brn_cond_e cond;
  logic      cond_brn;  // Conditional branch decoded

  function automatic logic cond_holds(brn_cond_e sel, logic c, logic z);
    case (sel)
      brn_c_clr: return !c;
      brn_c_set: return c;
      brn_z_set: return z;
      default:   return !z;
    endcase
  endfunction

  always_comb begin
    word     = '0;
    hit      = 1'b1;
    cond     = brn_c_clr;
    cond_brn = 1'b0;
    case (dec_in.opcode.rr)
      op_brcc: begin
        cond_brn = 1'b1;
        cond     = brn_c_clr;
      end
      op_brcs: begin
        cond_brn = 1'b1;
        cond     = brn_c_set;
      end
      op_breq: begin
        cond_brn = 1'b1;
        cond     = brn_z_set;
      end
      op_brne: begin
        cond_brn = 1'b1;
        cond     = brn_z_clr;
      end
      op_brn:  word.pc_ld = 1'b1;
      op_call: begin
        word.pc_ld        = 1'b1;
        word.sp_decr      = 1'b1;
        word.scr_we       = 1'b1;
        word.scr_data_sel = 1'b1;  // Push return address
        word.scr_addr_sel = scr_sp_dec;
      end
      op_ret, op_retid, op_retie: begin
        word.pc_ld        = 1'b1;
        word.pc_sel       = pc_stack;
        word.sp_incr      = 1'b1;
        word.scr_addr_sel = scr_sp;
      end
      op_clc: word.flg_c_clr = 1'b1;
      op_sec: word.flg_c_set = 1'b1;
      op_cli: word.i_clr     = 1'b1;
      op_sei: word.i_set     = 1'b1;
      default: hit = 1'b0;
    endcase

    // Interrupt returns restore C and Z from the shadow
    if (dec_in.opcode.rr == op_retid || dec_in.opcode.rr == op_retie) begin
      word.flg_ld_sel = 1'b1;
      word.flg_c_ld   = 1'b1;
      word.flg_z_ld   = 1'b1;
      word.i_clr      = (dec_in.opcode.rr == op_retid);
      word.i_set      = (dec_in.opcode.rr == op_retie);
    end

    if (cond_brn && cond_holds(cond, dec_in.c, dec_in.z)) begin
      word.pc_ld  = 1'b1;
      word.pc_sel = pc_branch;
    end
  end

endmodule

/* mem_stack_decoder.sv */
module mem_stack_decoder
  import cu_pkg::*;
(
  input  decode_in_t dec_in,
  output ctrl_word_t word,
  output logic       hit
);

  localparam logic [opcode_w-1:0] op_ld_rr = 7'b0001010;
  localparam logic [opcode_w-1:0] op_st_rr = 7'b0001011;
  localparam logic [opcode_w-1:0] op_push  = 7'b0100101;
  localparam logic [opcode_w-1:0] op_pop   = 7'b0100110;
  localparam logic [opcode_w-1:0] op_wsp   = 7'b0101000;

  localparam logic [opcode_hi_w-1:0] cls_in  = 5'b11001;
  localparam logic [opcode_hi_w-1:0] cls_out = 5'b11010;
  localparam logic [opcode_hi_w-1:0] cls_ld  = 5'b11100;
  localparam logic [opcode_hi_w-1:0] cls_st  = 5'b11101;

  always_comb begin
    word = '0;
    hit  = 1'b1;
    case (dec_in.opcode.rr)
      op_ld_rr: begin
        word.rf_wr        = 1'b1;
        word.rf_wr_sel    = rf_scratch;
        word.scr_addr_sel = scr_reg;
      end
      op_st_rr: begin
        word.scr_we       = 1'b1;  // Data from register X
        word.scr_addr_sel = scr_reg;
      end
      op_push: begin
        word.sp_decr      = 1'b1;
        word.scr_we       = 1'b1;
        word.scr_addr_sel = scr_sp_dec;
      end
      op_pop: begin
        word.sp_incr      = 1'b1;
        word.scr_addr_sel = scr_sp;
        word.rf_wr        = 1'b1;
        word.rf_wr_sel    = rf_scratch;
      end
      op_wsp: word.sp_ld = 1'b1;
      default: begin
        case (dec_in.opcode.ri.cls)
          cls_ld: begin
            word.rf_wr        = 1'b1;
            word.rf_wr_sel    = rf_scratch;
            word.scr_addr_sel = scr_imm;
          end
          cls_st: begin
            word.scr_we       = 1'b1;
            word.scr_addr_sel = scr_imm;
          end
          cls_in: begin
            word.rf_wr     = 1'b1;
            word.rf_wr_sel = rf_io;
          end
          cls_out: word.io_strb = 1'b1;  // Port id from immediate
          default: hit = 1'b0;
        endcase
      end
    endcase
  end

endmodule

/* alu_op_decoder.sv */
module alu_op_decoder
  import cu_pkg::*;
(
  input  decode_in_t dec_in,
  output ctrl_word_t word,
  output logic       hit
);

  // Register-register and single-register encodings
  localparam logic [opcode_w-1:0] op_and_rr  = 7'b0000000;
  localparam logic [opcode_w-1:0] op_or_rr   = 7'b0000001;
  localparam logic [opcode_w-1:0] op_exor_rr = 7'b0000010;
  localparam logic [opcode_w-1:0] op_test_rr = 7'b0000011;
  localparam logic [opcode_w-1:0] op_add_rr  = 7'b0000100;
  localparam logic [opcode_w-1:0] op_addc_rr = 7'b0000101;
  localparam logic [opcode_w-1:0] op_sub_rr  = 7'b0000110;
  localparam logic [opcode_w-1:0] op_subc_rr = 7'b0000111;
  localparam logic [opcode_w-1:0] op_cmp_rr  = 7'b0001000;
  localparam logic [opcode_w-1:0] op_mov_rr  = 7'b0001001;
  localparam logic [opcode_w-1:0] op_lsl     = 7'b0100000;
  localparam logic [opcode_w-1:0] op_lsr     = 7'b0100001;
  localparam logic [opcode_w-1:0] op_rol     = 7'b0100010;
  localparam logic [opcode_w-1:0] op_ror     = 7'b0100011;
  localparam logic [opcode_w-1:0] op_asr     = 7'b0100100;

  // Immediate classes
  localparam logic [opcode_hi_w-1:0] cls_and  = 5'b10000;
  localparam logic [opcode_hi_w-1:0] cls_or   = 5'b10001;
  localparam logic [opcode_hi_w-1:0] cls_exor = 5'b10010;
  localparam logic [opcode_hi_w-1:0] cls_test = 5'b10011;
  localparam logic [opcode_hi_w-1:0] cls_add  = 5'b10100;
  localparam logic [opcode_hi_w-1:0] cls_addc = 5'b10101;
  localparam logic [opcode_hi_w-1:0] cls_sub  = 5'b10110;
  localparam logic [opcode_hi_w-1:0] cls_subc = 5'b10111;
  localparam logic [opcode_hi_w-1:0] cls_cmp  = 5'b11000;
  localparam logic [opcode_hi_w-1:0] cls_mov  = 5'b11011;

  alu_sel_e alu_sel;
  logic     imm_form;  // Operand Y from the immediate field

  // Opcode to ALU function, RR first then the RI class
  always_comb begin
    alu_sel  = alu_add;
    imm_form = 1'b0;
    hit      = 1'b1;
    case (dec_in.opcode.rr)
      op_and_rr:  alu_sel = alu_and;
      op_or_rr:   alu_sel = alu_or;
      op_exor_rr: alu_sel = alu_exor;
      op_test_rr: alu_sel = alu_test;
      op_add_rr:  alu_sel = alu_add;
      op_addc_rr: alu_sel = alu_addc;
      op_sub_rr:  alu_sel = alu_sub;
      op_subc_rr: alu_sel = alu_subc;
      op_cmp_rr:  alu_sel = alu_cmp;
      op_mov_rr:  alu_sel = alu_mov;
      op_lsl:     alu_sel = alu_lsl;
      op_lsr:     alu_sel = alu_lsr;
      op_rol:     alu_sel = alu_rol;
      op_ror:     alu_sel = alu_ror;
      op_asr:     alu_sel = alu_asr;
      default: begin
        imm_form = 1'b1;
        case (dec_in.opcode.ri.cls)
          cls_and:  alu_sel = alu_and;
          cls_or:   alu_sel = alu_or;
          cls_exor: alu_sel = alu_exor;
          cls_test: alu_sel = alu_test;
          cls_add:  alu_sel = alu_add;
          cls_addc: alu_sel = alu_addc;
          cls_sub:  alu_sel = alu_sub;
          cls_subc: alu_sel = alu_subc;
          cls_cmp:  alu_sel = alu_cmp;
          cls_mov:  alu_sel = alu_mov;
          default: begin
            imm_form = 1'b0;
            hit      = 1'b0;
          end
        endcase
      end
    endcase
  end

  // Register write and flag actions follow the ALU function
  always_comb begin
    word = '0;
    if (hit) begin
      word.alu_sel     = alu_sel;
      word.alu_opy_sel = imm_form;
      word.rf_wr_sel   = rf_alu;
      word.rf_wr       = (alu_sel != alu_cmp) && (alu_sel != alu_test);
      case (alu_sel)
        alu_and, alu_or, alu_exor, alu_test: begin
          word.flg_c_clr = 1'b1;
          word.flg_z_ld  = 1'b1;
        end
        alu_add, alu_addc, alu_sub, alu_subc, alu_cmp,
        alu_lsl, alu_lsr, alu_rol, alu_ror, alu_asr: begin
          word.flg_c_ld = 1'b1;
          word.flg_z_ld = 1'b1;
        end
        default: ;  // MOV keeps both flags
      endcase
    end
  end

endmodule

/* cu_pkg.sv */
package cu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Opcode layout
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned opcode_hi_w = 5;
  localparam int unsigned opcode_lo_w = 2;
  localparam int unsigned opcode_w    = opcode_hi_w + opcode_lo_w;

  // Register-immediate view, the low bits belong to the immediate
  typedef struct packed {
    logic [opcode_hi_w-1:0] cls;
    logic [opcode_lo_w-1:0] dc;  // Don't care for decode
  } opcode_ri_t;

  // One opcode word, seen either whole or as an RI class
  typedef union packed {
    logic [opcode_w-1:0] rr;     // RR and no-operand instructions
    opcode_ri_t          ri;
  } opcode_u;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath selects
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_addc = 4'd1,
    alu_sub  = 4'd2,
    alu_subc = 4'd3,
    alu_cmp  = 4'd4,
    alu_and  = 4'd5,
    alu_or   = 4'd6,
    alu_exor = 4'd7,
    alu_test = 4'd8,
    alu_lsl  = 4'd9,
    alu_lsr  = 4'd10,
    alu_rol  = 4'd11,
    alu_ror  = 4'd12,
    alu_asr  = 4'd13,
    alu_mov  = 4'd14
  } alu_sel_e;

  typedef enum logic [1:0] {
    pc_branch = 2'd0,  // Immediate branch target
    pc_stack  = 2'd1   // Return address from scratch
  } pc_sel_e;

  typedef enum logic [1:0] {
    rf_alu     = 2'd0,
    rf_scratch = 2'd1,
    rf_io      = 2'd3
  } rf_wr_sel_e;

  typedef enum logic [1:0] {
    scr_reg    = 2'd0,  // Address from register Y
    scr_imm    = 2'd1,  // Address from immediate
    scr_sp     = 2'd2,  // Read at SP
    scr_sp_dec = 2'd3   // Write at SP-1
  } scr_addr_sel_e;

  typedef enum logic [1:0] {
    brn_c_clr = 2'd0,
    brn_c_set = 2'd1,
    brn_z_set = 2'd2,
    brn_z_clr = 2'd3
  } brn_cond_e;

  ////////////////////////////////////////////////////////////////////////////
  // Control word and decoder input
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic          pc_ld;
    pc_sel_e       pc_sel;
    logic          sp_ld;
    logic          sp_incr;
    logic          sp_decr;
    logic          rf_wr;
    rf_wr_sel_e    rf_wr_sel;
    logic          alu_opy_sel;   // 1 selects immediate operand
    alu_sel_e      alu_sel;
    logic          scr_we;
    logic          scr_data_sel;  // 1 stores the PC
    scr_addr_sel_e scr_addr_sel;
    logic          flg_c_set;
    logic          flg_c_clr;
    logic          flg_c_ld;
    logic          flg_z_ld;
    logic          flg_ld_sel;    // 1 restores flags from shadow
    logic          flg_shad_ld;   // No interrupt entry, stays low
    logic          i_set;
    logic          i_clr;
    logic          io_strb;
  } ctrl_word_t;

  typedef struct packed {
    opcode_u opcode;
    logic    c;
    logic    z;
  } decode_in_t;

endpackage
